//--- Makefile
# Verilator flow for the vector unit testbench

SIM = obj_dir/Vtb_vu

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module tb_vu -Mdir obj_dir -f vlog.f

run: compile
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test OK" sim.log || (echo "Simulation ended without passing"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- common/vu_pkg.sv
// Vector unit shared types
`include "vu_settings.svh"

package vu_pkg;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  typedef enum logic [3:0] {
    VADD    = 4'd0,
    VSUB    = 4'd1,
    VAND    = 4'd2,
    VXOR    = 4'd3,
    VADDX   = 4'd4,
    VMVX    = 4'd5,
    VREDSUM = 4'd6,
    VEXT    = 4'd7
  } vu_op_e;

  //////////////////////////////
  // Element and index types
  //////////////////////////////

  typedef logic [`VU_ELEM_W-1:0]            elem_t;
  typedef logic [$clog2(`VU_NR_VREGS)-1:0] vreg_idx_t;
  typedef logic [$clog2(`VU_NR_LANES)-1:0] lane_idx_t;

  //////////////////////////////
  // Instruction word
  //////////////////////////////

  // Same word seen as a three-register op or as a register plus scalar op
  typedef union packed {
    struct packed {
      vu_op_e                                        op;
      vreg_idx_t                                     vd;
      vreg_idx_t                                     vs1;
      vreg_idx_t                                     vs2;
      logic [`VU_INSN_W-4-3*$bits(vreg_idx_t)-1:0]   pad;
    } arith;
    struct packed {
      vu_op_e                                        op;
      vreg_idx_t                                     vd;
      vreg_idx_t                                     vs1;
      // Low bits carry the scalar, or the lane index for VEXT
      logic [`VU_INSN_W-4-2*$bits(vreg_idx_t)-1:0]   data;
    } scalar;
  } vu_insn_u;

endpackage

//--- common/vu_settings.svh
// Vector unit build settings
`ifndef VU_SETTINGS_SVH
`define VU_SETTINGS_SVH

// Parallel lanes, each holding one element of every register
`define VU_NR_LANES 4

// Element width in bits
`define VU_ELEM_W 16

// Architectural vector registers
`define VU_NR_VREGS 8

// Host instruction word
`define VU_INSN_W 32

`endif

//--- lane/vu_lane.sv
// Vector lane register slice and ALU
`timescale 1ns/1ps
`include "vu_settings.svh"

module vu_lane import vu_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      start_i,
  input  vu_op_e    op_i,
  input  vreg_idx_t vd_i,
  input  vreg_idx_t vs1_i,
  input  vreg_idx_t vs2_i,
  input  elem_t     scalar_i,
  output elem_t     rd_o
);

  elem_t vreg_q [`VU_NR_VREGS];
  elem_t opa_q;
  elem_t opb_q;
  logic  wr_q;
  elem_t alu_res;
  logic  alu_we;

  //////////////////////////////
  // Cycle 1, operand read
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      opa_q <= vreg_q[vs1_i];
      opb_q <= vreg_q[vs2_i];
    end
  end

  //////////////////////////////
  // Cycle 2, execute and write
  //////////////////////////////

  always_comb begin
    alu_res = opa_q;
    alu_we  = 1'b1;
    case (op_i)
      VADD:    alu_res = opa_q + opb_q;
      VSUB:    alu_res = opa_q - opb_q;
      VAND:    alu_res = opa_q & opb_q;
      VXOR:    alu_res = opa_q ^ opb_q;
      VADDX:   alu_res = opa_q + scalar_i;
      VMVX:    alu_res = scalar_i;
      // Reductions and extracts only read
      default: alu_we = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_q <= 1'b0;
      for (int r = 0; r < `VU_NR_VREGS; r++) begin
        vreg_q[r] <= '0;
      end
    end else begin
      wr_q <= start_i;
      if (wr_q && alu_we) begin
        vreg_q[vd_i] <= alu_res;
      end
    end
  end

  // vs1 element feeds the reduction
  assign rd_o = opa_q;

endmodule

//--- logic/vu_dispatcher.sv
// Host handshake and instruction decode
`timescale 1ns/1ps
`include "vu_settings.svh"

module vu_dispatcher import vu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Host side
  input  logic                  req_i,
  input  logic [`VU_INSN_W-1:0] insn_i,
  output logic                  ack_o,
  output elem_t                 result_o,
  // Sequencer side
  output logic                  issue_o,
  output vu_op_e                op_o,
  output vreg_idx_t             vd_o,
  output vreg_idx_t             vs1_o,
  output vreg_idx_t             vs2_o,
  output elem_t                 scalar_o,
  input  logic                  done_i,
  input  elem_t                 scalar_res_i
);

  localparam logic [1:0] IDLE     = 2'd0;
  localparam logic [1:0] BUSY     = 2'd1;
  localparam logic [1:0] ACK      = 2'd2;
  localparam logic [1:0] WAIT_LOW = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       accept;
  logic       decode_q;
  logic       issue_q;
  logic       has_scalar;
  vu_insn_u   insn_q;
  elem_t      result_q;

  assign accept = (state_q == IDLE) && req_i;

  //////////////////////////////
  // Four-phase FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (req_i) state_d = BUSY;
      BUSY:     if (done_i) state_d = ACK;
      // Host still holding req, keep ack up
      ACK:      state_d = req_i ? WAIT_LOW : IDLE;
      WAIT_LOW: if (!req_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= IDLE;
      decode_q <= 1'b0;
      issue_q  <= 1'b0;
    end else begin
      state_q  <= state_d;
      decode_q <= accept;
      issue_q  <= decode_q;
    end
  end

  //////////////////////////////
  // Decode and response
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= insn_i;
    end
    if (done_i) begin
      result_q <= has_scalar ? scalar_res_i : '0;
    end
  end

  // Only reductions and extracts return a value
  assign has_scalar = insn_q.arith.op inside {VREDSUM, VEXT};

  // Register fields from the arith view, operand from the scalar view
  assign op_o     = insn_q.arith.op;
  assign vd_o     = insn_q.arith.vd;
  assign vs1_o    = insn_q.arith.vs1;
  assign vs2_o    = insn_q.arith.vs2;
  assign scalar_o = insn_q.scalar.data[`VU_ELEM_W-1:0];

  assign issue_o  = issue_q;
  assign ack_o    = (state_q == ACK) || (state_q == WAIT_LOW);
  assign result_o = result_q;

endmodule

//--- logic/vu_reduce.sv
// Cross-lane sum and element select
`timescale 1ns/1ps
`include "vu_settings.svh"

module vu_reduce import vu_pkg::*; (
  input  elem_t     lanes_i [`VU_NR_LANES],
  input  lane_idx_t ext_idx_i,
  output elem_t     sum_o,
  output elem_t     ext_o
);

  // Wraps modulo the element width
  always_comb begin
    sum_o = '0;
    for (int l = 0; l < `VU_NR_LANES; l++) begin
      sum_o = sum_o + lanes_i[l];
    end
  end

  assign ext_o = lanes_i[ext_idx_i];

endmodule

//--- logic/vu_sequencer.sv
// Lane issue and completion tracking
`timescale 1ns/1ps

module vu_sequencer import vu_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // From the dispatcher
  input  logic      issue_i,
  input  vu_op_e    op_i,
  input  vreg_idx_t vd_i,
  input  vreg_idx_t vs1_i,
  input  vreg_idx_t vs2_i,
  input  elem_t     scalar_i,
  // Broadcast to all lanes
  output logic      lane_start_o,
  output vu_op_e    lane_op_o,
  output vreg_idx_t lane_vd_o,
  output vreg_idx_t lane_vs1_o,
  output vreg_idx_t lane_vs2_o,
  output elem_t     lane_scalar_o,
  // Reduction path
  output lane_idx_t ext_idx_o,
  input  elem_t     red_sum_i,
  input  elem_t     red_ext_i,
  // Back to the dispatcher
  output logic      done_o,
  output elem_t     scalar_res_o
);

  // Bit 0 marks the lane read cycle, bit 1 the write cycle
  logic [1:0] stage_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_q <= 2'b00;
    end else begin
      stage_q <= {stage_q[0], issue_i};
    end
  end

  // Lanes start in the issue cycle
  assign lane_start_o  = issue_i;
  assign lane_op_o     = op_i;
  assign lane_vd_o     = vd_i;
  assign lane_vs1_o    = vs1_i;
  assign lane_vs2_o    = vs2_i;
  assign lane_scalar_o = scalar_i;

  // Lane select for VEXT sits in the scalar low bits
  assign ext_idx_o = scalar_i[$bits(lane_idx_t)-1:0];

  assign done_o       = stage_q[1];
  assign scalar_res_o = (op_i == VREDSUM) ? red_sum_i : red_ext_i;

endmodule

//--- logic/vu_top.sv
// Vector unit top level
`timescale 1ns/1ps
`include "vu_settings.svh"

module vu_top import vu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  logic [`VU_INSN_W-1:0] insn_i,
  output logic                  ack_o,
  output elem_t                 result_o
);

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  logic      issue;
  vu_op_e    op;
  vreg_idx_t vd;
  vreg_idx_t vs1;
  vreg_idx_t vs2;
  elem_t     scalar;
  logic      done;
  elem_t     scalar_res;

  vu_dispatcher i_dispatcher (
    .clk_i       (clk_i     ),
    .reset_i     (reset_i   ),
    .req_i       (req_i     ),
    .insn_i      (insn_i    ),
    .ack_o       (ack_o     ),
    .result_o    (result_o  ),
    .issue_o     (issue     ),
    .op_o        (op        ),
    .vd_o        (vd        ),
    .vs1_o       (vs1       ),
    .vs2_o       (vs2       ),
    .scalar_o    (scalar    ),
    .done_i      (done      ),
    .scalar_res_i(scalar_res)
  );

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  logic      lane_start;
  vu_op_e    lane_op;
  vreg_idx_t lane_vd;
  vreg_idx_t lane_vs1;
  vreg_idx_t lane_vs2;
  elem_t     lane_scalar;
  lane_idx_t ext_idx;
  elem_t     red_sum;
  elem_t     red_ext;

  vu_sequencer i_sequencer (
    .clk_i        (clk_i      ),
    .reset_i      (reset_i    ),
    .issue_i      (issue      ),
    .op_i         (op         ),
    .vd_i         (vd         ),
    .vs1_i        (vs1        ),
    .vs2_i        (vs2        ),
    .scalar_i     (scalar     ),
    .lane_start_o (lane_start ),
    .lane_op_o    (lane_op    ),
    .lane_vd_o    (lane_vd    ),
    .lane_vs1_o   (lane_vs1   ),
    .lane_vs2_o   (lane_vs2   ),
    .lane_scalar_o(lane_scalar),
    .ext_idx_o    (ext_idx    ),
    .red_sum_i    (red_sum    ),
    .red_ext_i    (red_ext    ),
    .done_o       (done       ),
    .scalar_res_o (scalar_res )
  );

  //////////////////////////////
  // Lanes and reduction
  //////////////////////////////

  elem_t lane_rd [`VU_NR_LANES];

  for (genvar l = 0; l < `VU_NR_LANES; l++) begin : gen_lanes
    vu_lane i_lane (
      .clk_i   (clk_i      ),
      .reset_i (reset_i    ),
      .start_i (lane_start ),
      .op_i    (lane_op    ),
      .vd_i    (lane_vd    ),
      .vs1_i   (lane_vs1   ),
      .vs2_i   (lane_vs2   ),
      .scalar_i(lane_scalar),
      .rd_o    (lane_rd[l] )
    );
  end : gen_lanes

  vu_reduce i_reduce (
    .lanes_i  (lane_rd),
    .ext_idx_i(ext_idx),
    .sum_o    (red_sum),
    .ext_o    (red_ext)
  );

endmodule

//--- verif/tb_vu.sv
// Vector unit testbench
`timescale 1ns/1ps
`include "vu_settings.svh"

module tb_vu import vu_pkg::*; ();

  localparam int MAX_LINES   = 64;
  localparam int FIELDS      = 6;
  localparam int ACK_LATENCY = 4;

  logic                  clk_i;
  logic                  reset_i;
  logic                  req_i;
  logic [`VU_INSN_W-1:0] insn_i;
  logic                  ack_o;
  elem_t                 result_o;

  // Columns are opcode, vd, vs1, vs2, scalar, expected result
  elem_t stim_mem [MAX_LINES*FIELDS];
  int    nr_lines;
  int    cycle_cnt   = 0;
  int    cycle_limit = 100;

  vu_top dut (
    .clk_i   (clk_i   ),
    .reset_i (reset_i ),
    .req_i   (req_i   ),
    .insn_i  (insn_i  ),
    .ack_o   (ack_o   ),
    .result_o(result_o)
  );

  bind vu_top vu_props i_props (
    .clk_i  (clk_i  ),
    .reset_i(reset_i),
    .req_i  (req_i  ),
    .insn_i (insn_i ),
    .ack_o  (ack_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Failure handling
  //////////////////////////////

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_result(string name, elem_t exp, elem_t act);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s: result_o expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_latency(string name, int exp, int act);
    if (act != exp) begin
      abort_run($sformatf("[ERROR] %s: latency expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // Watchdog sized from the stimulus length
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles, ack_o never came", cycle_cnt));
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    vu_insn_u insn;
    vu_op_e   op;
    elem_t    expected;
    string    name;
    int       base;
    int       gap;
    int       hold;
    int       lat;

    void'($urandom(63));
    reset_i = 1'b1;
    req_i   = 1'b0;
    insn_i  = '0;

    // Opcode column still holding its fill value marks the end of the data
    for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
      stim_mem[i] = ~elem_t'(i);
    end
    $readmemh("verif/vu_stim.txt", stim_mem);
    nr_lines = 0;
    while (nr_lines < MAX_LINES &&
           stim_mem[nr_lines*FIELDS] != ~elem_t'(nr_lines*FIELDS)) begin
      nr_lines++;
    end
    if (nr_lines == 0) begin
      abort_run("No stimulus lines found in verif/vu_stim.txt");
    end
    cycle_limit = nr_lines * 12 + 50;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    for (int idx = 0; idx < nr_lines; idx++) begin
      base     = idx * FIELDS;
      op       = vu_op_e'(stim_mem[base][3:0]);
      expected = stim_mem[base+5];
      name     = $sformatf("line %0d %s", idx, op.name());

      insn                             = '0;
      insn.arith.op                    = op;
      insn.arith.vd                    = vreg_idx_t'(stim_mem[base+1]);
      insn.arith.vs1                   = vreg_idx_t'(stim_mem[base+2]);
      insn.arith.vs2                   = vreg_idx_t'(stim_mem[base+3]);
      insn.scalar.data[`VU_ELEM_W-1:0] = stim_mem[base+4];

      gap = $urandom % 4;
      repeat (gap) @(negedge clk_i);

      insn_i = insn;
      req_i  = 1'b1;
      lat    = 0;
      // Count rising edges after the one that samples the request
      @(negedge clk_i);
      while (!ack_o) begin
        @(negedge clk_i);
        lat++;
      end
      check_latency(name, ACK_LATENCY, lat);
      check_result(name, expected, result_o);

      // Some requests stay up longer, ack must hold and nothing reissues
      hold = idx % 3;
      repeat (hold) begin
        @(negedge clk_i);
        if (!ack_o) begin
          abort_run($sformatf("%s: ack_o dropped while req_i was still high", name));
        end
      end

      req_i = 1'b0;
      @(negedge clk_i);
      if (ack_o) begin
        abort_run($sformatf("%s: ack_o still high a cycle after req_i dropped", name));
      end
    end

    $display("Test OK");
    $finish;
  end

endmodule

//--- verif/vu_props.sv
// Host handshake assertions
`timescale 1ns/1ps
`include "vu_settings.svh"

module vu_props (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  req_i,
  input logic [`VU_INSN_W-1:0] insn_i,
  input logic                  ack_o
);

  // Reset clears the response
  ack_low_after_reset: assert property (@(posedge clk_i) reset_i |=> !ack_o)
    else $error("ack_o high right after reset");

  // Ack only ever answers a request
  ack_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_o) |-> $past(req_i))
    else $error("ack_o rose without a request");

  // Four-phase release
  ack_drops_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    (ack_o && !req_i) |=> !ack_o)
    else $error("ack_o stayed high after req_i was sampled low");

  // Host must not change the word mid request
  insn_held: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |=> (!req_i || $stable(insn_i)))
    else $error("insn_i changed while req_i was high");

endmodule

//--- verif/vu_stim.txt
// opcode vd vs1 vs2 scalar expected, all hex, one request per line
// 0 VADD 1 VSUB 2 VAND 3 VXOR 4 VADDX 5 VMVX 6 VREDSUM 7 VEXT
5 1 0 0 1234 0000
5 2 0 0 F00F 0000
5 3 0 0 8001 0000
7 0 1 0 0001 1234
7 0 3 0 0003 8001
6 0 1 0 0000 48D0
6 0 3 0 0000 0004
0 4 2 3 0000 0000
7 0 4 0 0002 7010
1 5 1 2 0000 0000
6 0 5 0 0000 8894
2 6 1 2 0000 0000
7 0 6 0 0000 1004
3 7 1 2 0000 0000
6 0 7 0 0000 88EC
4 2 2 0 1000 0000
4 1 1 0 0100 0000
6 0 1 0 0000 4CD0
7 0 2 0 0002 000F

//--- vlog.f
+incdir+common
common/vu_pkg.sv
logic/vu_dispatcher.sv
logic/vu_sequencer.sv
lane/vu_lane.sv
logic/vu_reduce.sv
logic/vu_top.sv
verif/vu_props.sv
verif/tb_vu.sv
